//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define XLEN    32
`define NREG    32
`define RADDR_W 5
`define BOOT_PC 32'h1c00_0000

// inst[31:15], 3R and shift-immediate forms
`define OP_ADD_W   17'h00020
`define OP_SUB_W   17'h00022
`define OP_SLT     17'h00024
`define OP_SLTU    17'h00025
`define OP_NOR     17'h00028
`define OP_AND     17'h00029
`define OP_OR      17'h0002a
`define OP_XOR     17'h0002b
`define OP_SLLI_W  17'h00081
`define OP_SRLI_W  17'h00089
`define OP_SRAI_W  17'h00091

// inst[31:22], 2RI12 forms
`define OP_ADDI_W  10'h00a
`define OP_LD_W    10'h0a2
`define OP_ST_W    10'h0a6

// inst[31:25]
`define OP_LU12I_W 7'h0a

// inst[31:26], branches
`define OP_JIRL    6'h13
`define OP_B       6'h14
`define OP_BL      6'h15
`define OP_BEQ     6'h16
`define OP_BNE     6'h17

`endif

//--- verilog/cpu_pkg.sv
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_B,
    BR_BL,
    BR_JIRL
  } br_kind_e;

  // bl and jirl carry their branch offset in rs2
  typedef struct packed {
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    rs1;
    logic [`XLEN-1:0]    rs2;
    logic [`XLEN-1:0]    imm;
    logic [`RADDR_W-1:0] ra1;
    logic [`RADDR_W-1:0] ra2;
    logic [`RADDR_W-1:0] rd;
    alu_op_e             alu_op;
    br_kind_e            br_kind;
    logic                src1_is_pc;
    logic                src2_is_imm;
    logic                rf_we;
    logic                mem_we;
    logic                mem_rd;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]    pc;
    logic [`XLEN-1:0]    result;
    logic [`XLEN-1:0]    store_data;
    logic [`RADDR_W-1:0] rd;
    logic                rf_we;
    logic                mem_we;
    logic                mem_rd;
  } ex_mem_t;

  typedef struct packed {
    logic                we;
    logic [`RADDR_W-1:0] addr;
    logic [`XLEN-1:0]    data;
  } rf_write_t;

endpackage

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module alu (
  input  wire cpu_pkg::alu_op_e op,
  input  wire [`XLEN-1:0]       a,
  input  wire [`XLEN-1:0]       b,
  output logic [`XLEN-1:0]      y
);
  import cpu_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLT:  y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU: y = {{(`XLEN-1){1'b0}}, a < b};
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_NOR:  y = ~(a | b);
      ALU_SLL:  y = a << b[4:0];
      ALU_SRL:  y = a >> b[4:0];
      ALU_SRA:  y = $signed(a) >>> b[4:0];
      // upper immediate already shifted by the decoder
      ALU_LUI:  y = b;
      default:  y = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_unit (
  input  wire              clk,
  input  wire              reset,
  input  wire              stall_fetch,
  input  wire              flush_if,
  input  wire              br_taken,
  input  wire [`XLEN-1:0]  br_target,
  input  wire [`XLEN-1:0]  inst_rdata,
  output logic [`XLEN-1:0] inst_addr,
  output logic [`XLEN-1:0] if_pc,
  output logic [`XLEN-1:0] if_inst
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] if2_pc;
  logic [`XLEN-1:0] if2_inst;
  logic [`XLEN-1:0] hold_inst;
  logic             if2_valid;
  logic             hold_valid;

  assign inst_addr = pc;
  // rom output moves on during a stall, the held copy does not
  assign if2_inst = hold_valid ? hold_inst : inst_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `BOOT_PC;
    end else if (br_taken) begin
      pc <= br_target;
    end else if (!stall_fetch) begin
      pc <= pc + `XLEN'd4;
    end
  end

  // IF1 -> IF2
  always_ff @(posedge clk) begin
    if (reset || flush_if) begin
      if2_valid <= 1'b0;
    end else if (!stall_fetch) begin
      if2_valid <= 1'b1;
    end
    if (!stall_fetch) begin
      if2_pc <= pc;
    end
  end

  // IF2 -> ID, an all-zero word decodes as a no-op
  always_ff @(posedge clk) begin
    if (reset || flush_if) begin
      if_inst <= '0;
    end else if (!stall_fetch) begin
      if_inst <= if2_valid ? if2_inst : '0;
    end
    if (!stall_fetch) begin
      if_pc <= if2_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flush_if || !stall_fetch) begin
      hold_valid <= 1'b0;
    end else begin
      hold_valid <= 1'b1;
    end
    if (stall_fetch && !hold_valid) begin
      hold_inst <= inst_rdata;
    end
  end

  // targets come from EX, so this covers the branch adder too
  a_pc_aligned : assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module inst_decoder (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     flush_id,
  input  wire [`XLEN-1:0]         if_pc,
  input  wire [`XLEN-1:0]         if_inst,
  input  wire [`XLEN-1:0]         rf_rdata1,
  input  wire [`XLEN-1:0]         rf_rdata2,
  output logic [`RADDR_W-1:0]     id_ra1,
  output logic [`RADDR_W-1:0]     id_ra2,
  output cpu_pkg::id_ex_t         id_ex
);
  import cpu_pkg::*;

  logic [16:0]         op17;
  logic [9:0]          op10;
  logic [6:0]          op7;
  logic [5:0]          op6;
  logic                is_reg_op;
  logic                is_shift;
  logic                is_addi;
  logic                is_ld;
  logic                is_st;
  logic                is_lu12i;
  logic                use_rj;
  logic                rf_we;
  logic [`XLEN-1:0]    offs16;
  logic [`XLEN-1:0]    offs26;
  logic [`XLEN-1:0]    imm;
  logic [`XLEN-1:0]    rs2_val;
  logic [`RADDR_W-1:0] rd;
  alu_op_e             alu_op;
  br_kind_e            br_kind;
  id_ex_t              id_ex_d;

  assign op17 = if_inst[31:15];
  assign op10 = if_inst[31:22];
  assign op7  = if_inst[31:25];
  assign op6  = if_inst[31:26];

  assign is_reg_op = op17 inside {`OP_ADD_W, `OP_SUB_W, `OP_SLT, `OP_SLTU,
                                  `OP_NOR, `OP_AND, `OP_OR, `OP_XOR};
  assign is_shift  = op17 inside {`OP_SLLI_W, `OP_SRLI_W, `OP_SRAI_W};
  assign is_addi   = op10 == `OP_ADDI_W;
  assign is_ld     = op10 == `OP_LD_W;
  assign is_st     = op10 == `OP_ST_W;
  assign is_lu12i  = op7 == `OP_LU12I_W;

  always_comb begin
    case (op17)
      `OP_SUB_W:  alu_op = ALU_SUB;
      `OP_SLT:    alu_op = ALU_SLT;
      `OP_SLTU:   alu_op = ALU_SLTU;
      `OP_NOR:    alu_op = ALU_NOR;
      `OP_AND:    alu_op = ALU_AND;
      `OP_OR:     alu_op = ALU_OR;
      `OP_XOR:    alu_op = ALU_XOR;
      `OP_SLLI_W: alu_op = ALU_SLL;
      `OP_SRLI_W: alu_op = ALU_SRL;
      `OP_SRAI_W: alu_op = ALU_SRA;
      default:    alu_op = is_lu12i ? ALU_LUI : ALU_ADD;
    endcase
  end

  always_comb begin
    case (op6)
      `OP_JIRL: br_kind = BR_JIRL;
      `OP_B:    br_kind = BR_B;
      `OP_BL:   br_kind = BR_BL;
      `OP_BEQ:  br_kind = BR_BEQ;
      `OP_BNE:  br_kind = BR_BNE;
      default:  br_kind = BR_NONE;
    endcase
  end

  assign offs16 = {{14{if_inst[25]}}, if_inst[25:10], 2'b00};
  assign offs26 = {{4{if_inst[9]}}, if_inst[9:0], if_inst[25:10], 2'b00};

  // link value pc+4 for bl and jirl
  always_comb begin
    if (br_kind == BR_BL || br_kind == BR_JIRL) begin
      imm = `XLEN'd4;
    end else if (is_lu12i) begin
      imm = {if_inst[24:5], 12'b0};
    end else if (is_shift) begin
      imm = {27'b0, if_inst[14:10]};
    end else if (br_kind == BR_B) begin
      imm = offs26;
    end else if (br_kind == BR_BEQ || br_kind == BR_BNE) begin
      imm = offs16;
    end else begin
      imm = {{20{if_inst[21]}}, if_inst[21:10]};
    end
  end

  assign use_rj = is_reg_op | is_shift | is_addi | is_ld | is_st |
                  br_kind inside {BR_BEQ, BR_BNE, BR_JIRL};
  assign id_ra1 = use_rj ? if_inst[9:5] : '0;
  // unused read ports stay on r0 so they never stall or forward
  assign id_ra2 = is_reg_op ? if_inst[14:10] :
                  (is_st || br_kind inside {BR_BEQ, BR_BNE}) ? if_inst[4:0] : '0;
  assign rd     = (br_kind == BR_BL) ? `RADDR_W'd1 : if_inst[4:0];
  assign rf_we  = is_reg_op | is_shift | is_addi | is_ld | is_lu12i |
                  br_kind inside {BR_BL, BR_JIRL};

  assign rs2_val = (br_kind == BR_BL)   ? offs26 :
                   (br_kind == BR_JIRL) ? offs16 : rf_rdata2;

  assign id_ex_d = '{pc: if_pc, rs1: rf_rdata1, rs2: rs2_val, imm: imm,
                     ra1: id_ra1, ra2: id_ra2, rd: rd, alu_op: alu_op, br_kind: br_kind,
                     src1_is_pc: br_kind inside {BR_BL, BR_JIRL},
                     src2_is_imm: rf_we & ~is_reg_op | is_st,
                     rf_we: rf_we, mem_we: is_st, mem_rd: is_ld};

  always_ff @(posedge clk) begin
    id_ex <= id_ex_d;
    if (reset || flush_id) begin
      id_ex.br_kind <= BR_NONE;
      id_ex.rf_we   <= 1'b0;
      id_ex.mem_we  <= 1'b0;
      id_ex.mem_rd  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module reg_file (
  input  wire                       clk,
  input  wire [`RADDR_W-1:0]        ra1,
  input  wire [`RADDR_W-1:0]        ra2,
  output logic [`XLEN-1:0]          rd1,
  output logic [`XLEN-1:0]          rd2,
  input  wire cpu_pkg::rf_write_t   wb
);

  logic [`XLEN-1:0] regs [`NREG];

  // r0 reads as zero, same-cycle write passes straight through
  assign rd1 = (ra1 == '0) ? '0 :
               (wb.we && wb.addr == ra1) ? wb.data : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 :
               (wb.we && wb.addr == ra2) ? wb.data : regs[ra2];

  always_ff @(posedge clk) begin
    if (wb.we && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module execute_unit (
  input  wire                       clk,
  input  wire                       reset,
  input  wire cpu_pkg::id_ex_t      id_ex,
  input  wire cpu_pkg::rf_write_t   mem_fwd,
  input  wire cpu_pkg::rf_write_t   wb,
  output logic                      br_taken,
  output logic [`XLEN-1:0]          br_target,
  output cpu_pkg::ex_mem_t          ex_mem,
  output logic [`RADDR_W-1:0]       ex_dst,
  output logic                      ex_rf_we,
  output logic                      ex_mem_rd
);
  import cpu_pkg::*;

  logic [`XLEN-1:0] rs1;
  logic [`XLEN-1:0] rs2;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_y;
  logic [`XLEN-1:0] tgt_base;
  logic [`XLEN-1:0] tgt_offs;

  // MEM wins over WB, r0 never forwarded
  function automatic logic [`XLEN-1:0] fwd_value(
    input logic [`RADDR_W-1:0] ra,
    input logic [`XLEN-1:0]    rf_val,
    input rf_write_t           m,
    input rf_write_t           w
  );
    if (ra != '0 && m.we && m.addr == ra) begin
      return m.data;
    end else if (ra != '0 && w.we && w.addr == ra) begin
      return w.data;
    end
    return rf_val;
  endfunction

  assign rs1 = fwd_value(id_ex.ra1, id_ex.rs1, mem_fwd, wb);
  assign rs2 = fwd_value(id_ex.ra2, id_ex.rs2, mem_fwd, wb);

  assign alu_a = id_ex.src1_is_pc ? id_ex.pc : rs1;
  assign alu_b = id_ex.src2_is_imm ? id_ex.imm : rs2;

  alu u_alu (
    .op (id_ex.alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  always_comb begin
    case (id_ex.br_kind)
      BR_BEQ:                br_taken = rs1 == rs2;
      BR_BNE:                br_taken = rs1 != rs2;
      BR_B, BR_BL, BR_JIRL:  br_taken = 1'b1;
      default:               br_taken = 1'b0;
    endcase
  end

  // imm holds the link constant for bl and jirl, the offset sits in rs2
  assign tgt_base  = (id_ex.br_kind == BR_JIRL) ? rs1 : id_ex.pc;
  assign tgt_offs  = (id_ex.br_kind inside {BR_BL, BR_JIRL}) ? rs2 : id_ex.imm;
  assign br_target = tgt_base + tgt_offs;

  assign ex_dst    = id_ex.rd;
  assign ex_rf_we  = id_ex.rf_we;
  assign ex_mem_rd = id_ex.mem_rd;

  always_ff @(posedge clk) begin
    ex_mem <= '{pc: id_ex.pc, result: alu_y, store_data: rs2, rd: id_ex.rd,
                rf_we: id_ex.rf_we, mem_we: id_ex.mem_we, mem_rd: id_ex.mem_rd};
    if (reset) begin
      ex_mem.rf_we  <= 1'b0;
      ex_mem.mem_we <= 1'b0;
      ex_mem.mem_rd <= 1'b0;
    end
  end

  // only real branches redirect, and the slot behind them becomes a bubble
  a_br_taken_kind : assert property (@(posedge clk) disable iff (reset)
    br_taken |-> (id_ex.br_kind != BR_NONE) ##1 (!id_ex.rf_we && !id_ex.mem_we));

endmodule

`default_nettype wire

//--- verilog/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module mem_wb_stage (
  input  wire                       clk,
  input  wire                       reset,
  input  wire cpu_pkg::ex_mem_t     ex_mem,
  input  wire [`XLEN-1:0]           data_rdata,
  output logic                      data_we,
  output logic [`XLEN-1:0]          data_addr,
  output logic [`XLEN-1:0]          data_wdata,
  output cpu_pkg::rf_write_t        mem_fwd,
  output cpu_pkg::rf_write_t        wb,
  output logic [`XLEN-1:0]          debug_wb_pc,
  output logic                      debug_wb_rf_we,
  output logic [`RADDR_W-1:0]       debug_wb_rf_wnum,
  output logic [`XLEN-1:0]          debug_wb_rf_wdata
);
  import cpu_pkg::*;

  logic [`XLEN-1:0] mem_result;
  logic [`XLEN-1:0] wb_pc;
  rf_write_t        wb_d;

  assign data_we    = ex_mem.mem_we;
  assign data_addr  = ex_mem.result;
  assign data_wdata = ex_mem.store_data;

  // data ram reads in the same cycle
  assign mem_result = ex_mem.mem_rd ? data_rdata : ex_mem.result;
  assign wb_d       = '{we: ex_mem.rf_we, addr: ex_mem.rd, data: mem_result};

  // a load has no value yet in MEM
  assign mem_fwd = '{we: ex_mem.rf_we & ~ex_mem.mem_rd, addr: ex_mem.rd, data: ex_mem.result};

  always_ff @(posedge clk) begin
    wb    <= wb_d;
    wb_pc <= ex_mem.pc;
    if (reset) begin
      wb.we <= 1'b0;
    end
  end

  assign debug_wb_pc       = wb_pc;
  assign debug_wb_rf_we    = wb.we;
  assign debug_wb_rf_wnum  = wb.addr;
  assign debug_wb_rf_wdata = wb.data;

  // a load is never a store, and always reaches write-back
  a_load_not_store : assert property (@(posedge clk) disable iff (reset)
    ex_mem.mem_rd |-> !ex_mem.mem_we ##1 wb.we);

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module hazard_unit (
  input  wire [`RADDR_W-1:0] id_ra1,
  input  wire [`RADDR_W-1:0] id_ra2,
  input  wire [`RADDR_W-1:0] ex_dst,
  input  wire                ex_rf_we,
  input  wire                ex_mem_rd,
  input  wire                br_taken,
  output logic               stall_fetch,
  output logic               flush_if,
  output logic               flush_id
);

  logic load_use;

  // load in EX feeding the instruction in ID
  assign load_use = ex_mem_rd && ex_rf_we && ex_dst != '0 &&
                    (ex_dst == id_ra1 || ex_dst == id_ra2);

  // a taken branch kills the dependent instruction anyway
  assign stall_fetch = load_use && !br_taken;
  assign flush_if    = br_taken;
  assign flush_id    = br_taken || load_use;

endmodule

`default_nettype wire

//--- verilog/loong_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module loong_cpu_top (
  input  wire                 clk,
  input  wire                 reset,
  output logic [`XLEN-1:0]    inst_addr,
  input  wire [`XLEN-1:0]     inst_rdata,
  output logic                data_we,
  output logic [`XLEN-1:0]    data_addr,
  output logic [`XLEN-1:0]    data_wdata,
  input  wire [`XLEN-1:0]     data_rdata,
  output logic [`XLEN-1:0]    debug_wb_pc,
  output logic                debug_wb_rf_we,
  output logic [`RADDR_W-1:0] debug_wb_rf_wnum,
  output logic [`XLEN-1:0]    debug_wb_rf_wdata
);
  import cpu_pkg::*;

  logic [`XLEN-1:0]    if_pc;
  logic [`XLEN-1:0]    if_inst;
  logic [`XLEN-1:0]    br_target;
  logic [`XLEN-1:0]    rf_rdata1;
  logic [`XLEN-1:0]    rf_rdata2;
  logic [`RADDR_W-1:0] id_ra1;
  logic [`RADDR_W-1:0] id_ra2;
  logic [`RADDR_W-1:0] ex_dst;
  logic                br_taken;
  logic                ex_rf_we;
  logic                ex_mem_rd;
  logic                stall_fetch;
  logic                flush_if;
  logic                flush_id;
  id_ex_t              id_ex;
  ex_mem_t             ex_mem;
  rf_write_t           mem_fwd;
  rf_write_t           wb;

  fetch_unit u_fetch (
    .clk, .reset, .stall_fetch, .flush_if, .br_taken, .br_target,
    .inst_rdata, .inst_addr, .if_pc, .if_inst
  );

  inst_decoder u_decoder (
    .clk, .reset, .flush_id, .if_pc, .if_inst, .rf_rdata1, .rf_rdata2,
    .id_ra1, .id_ra2, .id_ex
  );

  reg_file u_reg_file (
    .clk, .ra1(id_ra1), .ra2(id_ra2), .rd1(rf_rdata1), .rd2(rf_rdata2), .wb
  );

  execute_unit u_execute (
    .clk, .reset, .id_ex, .mem_fwd, .wb, .br_taken, .br_target,
    .ex_mem, .ex_dst, .ex_rf_we, .ex_mem_rd
  );

  mem_wb_stage u_mem_wb (
    .clk, .reset, .ex_mem, .data_rdata, .data_we, .data_addr, .data_wdata,
    .mem_fwd, .wb, .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
  );

  hazard_unit u_hazard (
    .id_ra1, .id_ra2, .ex_dst, .ex_rf_we, .ex_mem_rd, .br_taken,
    .stall_fetch, .flush_if, .flush_id
  );

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_mem_model (
  input  wire         clk,
  input  wire  [31:0] inst_addr,
  output logic [31:0] inst_rdata,
  input  wire         data_we,
  input  wire  [31:0] data_addr,
  input  wire  [31:0] data_wdata,
  output logic [31:0] data_rdata
);

  localparam logic [16:0] op_add_w  = 17'h00020;
  localparam logic [16:0] op_sub_w  = 17'h00022;
  localparam logic [16:0] op_slt    = 17'h00024;
  localparam logic [16:0] op_sltu   = 17'h00025;
  localparam logic [16:0] op_nor    = 17'h00028;
  localparam logic [16:0] op_and    = 17'h00029;
  localparam logic [16:0] op_or     = 17'h0002a;
  localparam logic [16:0] op_xor    = 17'h0002b;
  localparam logic [16:0] op_slli_w = 17'h00081;
  localparam logic [16:0] op_srli_w = 17'h00089;
  localparam logic [16:0] op_srai_w = 17'h00091;
  localparam logic [9:0]  op_addi_w = 10'h00a;
  localparam logic [9:0]  op_ld_w   = 10'h0a2;
  localparam logic [9:0]  op_st_w   = 10'h0a6;
  localparam logic [6:0]  op_lu12i  = 7'h0a;
  localparam logic [5:0]  op_jirl   = 6'h13;
  localparam logic [5:0]  op_b      = 6'h14;
  localparam logic [5:0]  op_bl     = 6'h15;
  localparam logic [5:0]  op_beq    = 6'h16;
  localparam logic [5:0]  op_bne    = 6'h17;

  logic [31:0] rom [64];
  logic [31:0] ram [128];
  logic [31:0] rom_off;

  // also used for the shift forms, ui5 sits in the rk slot
  function automatic logic [31:0] three_reg(input logic [16:0] op, input logic [4:0] rk,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic logic [31:0] reg_imm12(input logic [9:0] op, input logic [11:0] si12,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {op, si12, rj, rd};
  endfunction

  function automatic logic [31:0] upper20(input logic [6:0] op, input logic [19:0] si20,
                                          input logic [4:0] rd);
    return {op, si20, rd};
  endfunction

  function automatic logic [31:0] branch16(input logic [5:0] op, input logic [15:0] offs,
                                           input logic [4:0] rj, input logic [4:0] rd);
    return {op, offs, rj, rd};
  endfunction

  function automatic logic [31:0] jump26(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
  endfunction

  initial begin
    inst_rdata = '0;
    for (int i = 0; i < 64; i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < 128; i++) begin
      ram[i] = 32'h5a5a_0000 ^ 32'(i * 4);
    end
    // dependent ALU chain
    rom[0]  = upper20(op_lu12i, 20'h12345, 5'd1);
    rom[1]  = reg_imm12(op_addi_w, 12'h678, 5'd1, 5'd1);
    rom[2]  = reg_imm12(op_addi_w, 12'hfff, 5'd0, 5'd2);
    rom[3]  = three_reg(op_add_w, 5'd2, 5'd1, 5'd3);
    rom[4]  = three_reg(op_sub_w, 5'd1, 5'd3, 5'd4);
    rom[5]  = three_reg(op_slt, 5'd1, 5'd4, 5'd5);
    rom[6]  = three_reg(op_sltu, 5'd1, 5'd4, 5'd6);
    rom[7]  = three_reg(op_and, 5'd3, 5'd1, 5'd7);
    rom[8]  = three_reg(op_or, 5'd5, 5'd7, 5'd8);
    rom[9]  = three_reg(op_xor, 5'd1, 5'd8, 5'd9);
    rom[10] = three_reg(op_nor, 5'd0, 5'd9, 5'd10);
    rom[11] = three_reg(op_slli_w, 5'd4, 5'd1, 5'd11);
    rom[12] = three_reg(op_srli_w, 5'd8, 5'd10, 5'd12);
    rom[13] = three_reg(op_srai_w, 5'd1, 5'd10, 5'd13);
    // stores, then two load-use pairs
    rom[14] = reg_imm12(op_addi_w, 12'h100, 5'd0, 5'd14);
    rom[15] = reg_imm12(op_st_w, 12'h000, 5'd14, 5'd1);
    rom[16] = reg_imm12(op_st_w, 12'h008, 5'd14, 5'd11);
    rom[17] = reg_imm12(op_ld_w, 12'h000, 5'd14, 5'd15);
    rom[18] = three_reg(op_add_w, 5'd15, 5'd15, 5'd16);
    rom[19] = reg_imm12(op_ld_w, 12'h008, 5'd14, 5'd17);
    rom[20] = reg_imm12(op_addi_w, 12'h001, 5'd17, 5'd18);
    // control flow, every skipped slot would write r20
    rom[21] = branch16(op_beq, 16'd3, 5'd15, 5'd1);
    rom[22] = reg_imm12(op_addi_w, 12'h111, 5'd0, 5'd20);
    rom[23] = reg_imm12(op_addi_w, 12'h222, 5'd0, 5'd20);
    rom[24] = branch16(op_bne, 16'd2, 5'd6, 5'd0);
    rom[25] = reg_imm12(op_addi_w, 12'h333, 5'd0, 5'd21);
    rom[26] = jump26(op_bl, 26'd3);
    rom[27] = reg_imm12(op_addi_w, 12'h444, 5'd0, 5'd20);
    rom[28] = reg_imm12(op_addi_w, 12'h555, 5'd0, 5'd20);
    rom[29] = upper20(op_lu12i, 20'h1c000, 5'd22);
    rom[30] = branch16(op_jirl, 16'd34, 5'd22, 5'd23);
    rom[31] = reg_imm12(op_addi_w, 12'h666, 5'd0, 5'd20);
    rom[32] = reg_imm12(op_addi_w, 12'h777, 5'd0, 5'd20);
    rom[33] = reg_imm12(op_addi_w, 12'h788, 5'd0, 5'd20);
    rom[34] = jump26(op_b, 26'd3);
    rom[35] = reg_imm12(op_addi_w, 12'h799, 5'd0, 5'd20);
    rom[36] = reg_imm12(op_addi_w, 12'h7aa, 5'd0, 5'd20);
    rom[37] = three_reg(op_add_w, 5'd23, 5'd1, 5'd24);
    // park here
    rom[38] = jump26(op_b, 26'd0);
  end

  assign rom_off = inst_addr - `BOOT_PC;

  always @(posedge clk) begin
    if (rom_off < 32'd256) begin
      inst_rdata <= rom[rom_off[7:2]];
    end else begin
      inst_rdata <= '0;
    end
  end

  assign data_rdata = $isunknown(data_addr) ? '0 : ram[data_addr[8:2]];

  always @(posedge clk) begin
    if (data_we) begin
      ram[data_addr[8:2]] <= data_wdata;
    end
  end

endmodule

`default_nettype wire

//--- test/tb_loong_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module tb_loong_cpu;

  localparam int PROG_LEN     = 39;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_CYCLES   = RESET_CYCLES + PROG_LEN * 4 + 64;

  logic        clk = 1'b0;
  logic        reset;
  logic [31:0] inst_addr;
  logic [31:0] inst_rdata;
  logic        data_we;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;
  logic [31:0] debug_wb_pc;
  logic        debug_wb_rf_we;
  logic [4:0]  debug_wb_rf_wnum;
  logic [31:0] debug_wb_rf_wdata;

  logic [31:0] gold_pc [32];
  logic [4:0]  gold_wnum [32];
  logic [31:0] gold_wdata [32];
  logic [31:0] gold_st_addr [4];
  logic [31:0] gold_st_data [4];
  logic [31:0] exp_pc;
  logic [4:0]  exp_wnum;
  logic [31:0] exp_wdata;
  logic [31:0] exp_st_addr;
  logic [31:0] exp_st_data;
  int          n_commits = 0;
  int          n_stores = 0;
  int          commit_idx = 0;
  int          store_idx = 0;
  int          cycles = 0;
  int          errors = 0;

  loong_cpu_top loong_cpu_top_i (
    .clk, .reset, .inst_addr, .inst_rdata, .data_we, .data_addr, .data_wdata,
    .data_rdata, .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
  );

  tb_mem_model mem_model_i (
    .clk, .inst_addr, .inst_rdata, .data_we, .data_addr, .data_wdata, .data_rdata
  );

  always #20 clk = ~clk;

  task automatic expect_write(input int word, input logic [4:0] wnum, input logic [31:0] wdata);
    gold_pc[n_commits]    = `BOOT_PC + 32'(word * 4);
    gold_wnum[n_commits]  = wnum;
    gold_wdata[n_commits] = wdata;
    n_commits++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    gold_st_addr[n_stores] = addr;
    gold_st_data[n_stores] = data;
    n_stores++;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!reset && debug_wb_rf_we) begin
      commit_idx <= commit_idx + 1;
    end
    if (!reset && data_we) begin
      store_idx <= store_idx + 1;
    end
  end

  assign exp_pc      = gold_pc[commit_idx];
  assign exp_wnum    = gold_wnum[commit_idx];
  assign exp_wdata   = gold_wdata[commit_idx];
  assign exp_st_addr = gold_st_addr[store_idx];
  assign exp_st_data = gold_st_data[store_idx];

  // strobes quiet in reset and the cycle after, once the flops have seen a reset edge
  a_reset_wb : assert property (@(posedge clk)
    (cycles > 0 && (reset || $fell(reset))) |-> !debug_wb_rf_we)
    else report_mismatch("debug_wb_rf_we", $sampled(debug_wb_rf_we), 0);
  a_reset_dwe : assert property (@(posedge clk)
    (cycles > 0 && (reset || $fell(reset))) |-> !data_we)
    else report_mismatch("data_we", $sampled(data_we), 0);
  a_boot_pc : assert property (@(posedge clk) $fell(reset) |-> inst_addr == `BOOT_PC)
    else report_mismatch("inst_addr", $sampled(inst_addr), `BOOT_PC);

  a_commit_pc : assert property (@(posedge clk)
    (!reset && debug_wb_rf_we && commit_idx < n_commits) |-> debug_wb_pc == exp_pc)
    else report_mismatch("debug_wb_pc", $sampled(debug_wb_pc), $sampled(exp_pc));
  a_commit_wnum : assert property (@(posedge clk)
    (!reset && debug_wb_rf_we && commit_idx < n_commits) |-> debug_wb_rf_wnum == exp_wnum)
    else report_mismatch("debug_wb_rf_wnum", $sampled(debug_wb_rf_wnum), $sampled(exp_wnum));
  a_commit_wdata : assert property (@(posedge clk)
    (!reset && debug_wb_rf_we && commit_idx < n_commits) |-> debug_wb_rf_wdata == exp_wdata)
    else report_mismatch("debug_wb_rf_wdata", $sampled(debug_wb_rf_wdata), $sampled(exp_wdata));
  a_extra_commit : assert property (@(posedge clk)
    (!reset && debug_wb_rf_we) |-> commit_idx < n_commits)
    else begin
      errors++;
      $display("unexpected write-back at %0t after the last expected one", $time);
    end

  a_store_addr : assert property (@(posedge clk)
    (!reset && data_we && store_idx < n_stores) |-> data_addr == exp_st_addr)
    else report_mismatch("data_addr", $sampled(data_addr), $sampled(exp_st_addr));
  a_store_data : assert property (@(posedge clk)
    (!reset && data_we && store_idx < n_stores) |-> data_wdata == exp_st_data)
    else report_mismatch("data_wdata", $sampled(data_wdata), $sampled(exp_st_data));
  a_extra_store : assert property (@(posedge clk) (!reset && data_we) |-> store_idx < n_stores)
    else begin
      errors++;
      $display("unexpected store at %0t after the last expected one", $time);
    end

  initial begin
    reset = 1'b1;
    expect_write(0, 5'd1, 32'h1234_5000);
    expect_write(1, 5'd1, 32'h1234_5678);
    expect_write(2, 5'd2, 32'hffff_ffff);
    expect_write(3, 5'd3, 32'h1234_5677);
    expect_write(4, 5'd4, 32'hffff_ffff);
    expect_write(5, 5'd5, 32'h0000_0001);
    expect_write(6, 5'd6, 32'h0000_0000);
    expect_write(7, 5'd7, 32'h1234_5670);
    expect_write(8, 5'd8, 32'h1234_5671);
    expect_write(9, 5'd9, 32'h0000_0009);
    expect_write(10, 5'd10, 32'hffff_fff6);
    expect_write(11, 5'd11, 32'h2345_6780);
    expect_write(12, 5'd12, 32'h00ff_ffff);
    expect_write(13, 5'd13, 32'hffff_fffb);
    expect_write(14, 5'd14, 32'h0000_0100);
    expect_write(17, 5'd15, 32'h1234_5678);
    expect_write(18, 5'd16, 32'h2468_acf0);
    expect_write(19, 5'd17, 32'h2345_6780);
    expect_write(20, 5'd18, 32'h2345_6781);
    expect_write(25, 5'd21, 32'h0000_0333);
    // bl link
    expect_write(26, 5'd1, `BOOT_PC + 32'h6c);
    expect_write(29, 5'd22, 32'h1c00_0000);
    // jirl link
    expect_write(30, 5'd23, `BOOT_PC + 32'h7c);
    expect_write(37, 5'd24, 32'h3800_00e8);
    expect_store(32'h0000_0100, 32'h1234_5678);
    expect_store(32'h0000_0108, 32'h2345_6780);

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    while (commit_idx < n_commits && cycles < MAX_CYCLES) begin
      @(posedge clk);
    end
    // keep the final loop spinning to catch stray writes
    repeat (8) @(posedge clk);
    if (commit_idx < n_commits) begin
      errors++;
      $display("timeout after %0d cycles with %0d of %0d write-backs seen",
               cycles, commit_idx, n_commits);
    end
    if (store_idx != n_stores) begin
      errors++;
      $display("saw %0d stores where %0d were expected", store_idx, n_stores);
    end
    $display("errors: %0d, write-backs: %0d of %0d, stores: %0d of %0d",
             errors, commit_idx, n_commits, store_idx, n_stores);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/mem_wb_stage.sv
verilog/hazard_unit.sv
verilog/loong_cpu_top.sv
test/tb_mem_model.sv
test/tb_loong_cpu.sv
